// ==== hdl/core_pkg.sv ====
package core_pkg;

    typedef logic [31:0] word_t;    // data, address or instruction
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B   // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_LS,
        FWD_WB
    } fwd_sel_e;

    // decode -> execute
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        reg_idx_t rs1;   // zero when the field is not a source
        reg_idx_t rs2;
        reg_idx_t rd;
        alu_op_e  alu_op;
        logic     use_imm;
        logic     is_load;
        logic     is_store;
        logic     is_branch_ne;
        logic     is_branch_eq;
        logic     is_jal;
        logic     wb_en;
    } id_ex_t;

    // execute -> load/store
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    result;   // address for loads and stores
        word_t    store_data;
        reg_idx_t rd;
        logic     is_load;
        logic     is_store;
        logic     wb_en;
    } ex_ls_t;

    // register write port and retire record
    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    data;
        logic     wb_en;
    } wb_t;

endpackage

// ==== hdl/bus_pkg.sv ====
package bus_pkg;

    typedef logic [3:0] sel_t;   // byte lanes

    // wishbone classic, master side
    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        core_pkg::word_t adr;
        core_pkg::word_t dat;
        sel_t            sel;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        core_pkg::word_t dat;
    } wb_rsp_t;

endpackage

// ==== hdl/if_stage.sv ====
module if_stage #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             stall_i,
    input  logic             redirect_i,
    input  core_pkg::word_t  target_i,
    output bus_pkg::wb_req_t ibus_req_o,
    input  bus_pkg::wb_rsp_t ibus_rsp_i,
    output core_pkg::word_t  instr_o,
    output core_pkg::word_t  pc_o,
    output logic             valid_o,
    output logic             fetch_wait_o
);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DISCARD
    } fetch_state_e;

    fetch_state_e    state_q;
    core_pkg::word_t pc_q;        // address on the bus
    core_pkg::word_t target_q;    // restart point while discarding
    core_pkg::word_t held_instr_q;
    core_pkg::word_t held_pc_q;
    logic            held_q;
    logic            ack;
    logic            take_redirect;

    assign ack           = (state_q != IDLE) && ibus_rsp_i.ack;
    assign take_redirect = redirect_i && !stall_i;

    always_comb begin
        ibus_req_o     = '0;
        ibus_req_o.cyc = (state_q != IDLE);
        ibus_req_o.stb = (state_q != IDLE);
        ibus_req_o.adr = pc_q;
        ibus_req_o.sel = '1;
    end

    assign valid_o      = held_q || (state_q == BUSY && ack);
    assign instr_o      = held_q ? held_instr_q : ibus_rsp_i.dat;
    assign pc_o         = held_q ? held_pc_q : pc_q;
    assign fetch_wait_o = !valid_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            pc_q    <= RESET_PC;
            held_q  <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (!held_q || !stall_i) begin   // buffer drained or never filled
                        held_q  <= 1'b0;
                        state_q <= BUSY;
                        if (take_redirect) begin
                            pc_q <= target_i;
                        end
                    end
                end
                BUSY: begin
                    if (take_redirect) begin
                        if (ack) begin
                            pc_q <= target_i;
                        end else begin
                            state_q <= DISCARD;   // let the old read finish
                        end
                    end else if (ack) begin
                        pc_q <= pc_q + 32'd4;
                        if (stall_i) begin
                            held_q  <= 1'b1;
                            state_q <= IDLE;
                        end
                    end
                end
                DISCARD: begin
                    if (ack) begin
                        pc_q    <= take_redirect ? target_i : target_q;
                        state_q <= BUSY;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == BUSY && ack && stall_i) begin
            held_instr_q <= ibus_rsp_i.dat;
            held_pc_q    <= pc_q;
        end
        if (take_redirect) begin
            target_q <= target_i;
        end
    end

    a_ibus_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        ibus_req_o.stb && !ibus_rsp_i.ack |=> $stable(ibus_req_o));

endmodule

// ==== hdl/id_stage.sv ====
module id_stage (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  core_pkg::word_t   instr_i,
    input  core_pkg::word_t   pc_i,
    input  logic              valid_i,
    input  core_pkg::wb_t     wb_i,
    input  core_pkg::id_ex_t  ex_i,
    output core_pkg::id_ex_t  id_ex_o,
    output logic              load_use_o
);

    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    logic            valid_q;
    core_pkg::word_t pc_q;
    core_pkg::word_t instr_q;
    core_pkg::word_t regs [1:31];   // x0 is not stored
    logic            use_rs1;
    logic            use_rs2;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pc_q    <= pc_i;
            instr_q <= instr_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.wb_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    always_comb begin
        id_ex_o        = '0;
        id_ex_o.valid  = valid_q;
        id_ex_o.pc     = pc_q;
        id_ex_o.rd     = instr_q[11:7];
        id_ex_o.alu_op = core_pkg::ALU_ADD;
        use_rs1        = 1'b0;
        use_rs2        = 1'b0;
        case (instr_q[6:0])
            OP_IMM: begin   // addi only
                id_ex_o.imm     = {{20{instr_q[31]}}, instr_q[31:20]};
                id_ex_o.use_imm = 1'b1;
                id_ex_o.wb_en   = (instr_q[14:12] == 3'b000);
                use_rs1         = 1'b1;
            end
            OP_REG: begin
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                id_ex_o.wb_en = 1'b1;
                case (instr_q[14:12])
                    3'b000:  id_ex_o.alu_op = instr_q[30] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
                    3'b100:  id_ex_o.alu_op = core_pkg::ALU_XOR;
                    3'b110:  id_ex_o.alu_op = core_pkg::ALU_OR;
                    3'b111:  id_ex_o.alu_op = core_pkg::ALU_AND;
                    default: id_ex_o.wb_en  = 1'b0;
                endcase
            end
            OP_LUI: begin
                id_ex_o.imm     = {instr_q[31:12], 12'b0};
                id_ex_o.use_imm = 1'b1;
                id_ex_o.alu_op  = core_pkg::ALU_PASS_B;
                id_ex_o.wb_en   = 1'b1;
            end
            OP_LOAD: begin
                id_ex_o.imm     = {{20{instr_q[31]}}, instr_q[31:20]};
                id_ex_o.use_imm = 1'b1;
                id_ex_o.is_load = 1'b1;
                id_ex_o.wb_en   = 1'b1;
                use_rs1         = 1'b1;
            end
            OP_STORE: begin
                id_ex_o.imm      = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
                id_ex_o.use_imm  = 1'b1;
                id_ex_o.is_store = 1'b1;
                use_rs1          = 1'b1;
                use_rs2          = 1'b1;
            end
            OP_BRANCH: begin
                id_ex_o.imm = {{19{instr_q[31]}}, instr_q[31], instr_q[7],
                               instr_q[30:25], instr_q[11:8], 1'b0};
                id_ex_o.is_branch_eq = (instr_q[14:12] == 3'b000);
                id_ex_o.is_branch_ne = (instr_q[14:12] == 3'b001);
                use_rs1              = 1'b1;
                use_rs2              = 1'b1;
            end
            OP_JAL: begin
                id_ex_o.imm = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12],
                               instr_q[20], instr_q[30:21], 1'b0};
                id_ex_o.is_jal = 1'b1;
                id_ex_o.wb_en  = 1'b1;
            end
            default: ;
        endcase
        id_ex_o.rs1 = use_rs1 ? instr_q[19:15] : '0;
        id_ex_o.rs2 = use_rs2 ? instr_q[24:20] : '0;
        if (id_ex_o.rd == '0) begin
            id_ex_o.wb_en = 1'b0;   // x0 writes retire with no effect
        end
        id_ex_o.rs1_val = (id_ex_o.rs1 == '0) ? '0 : regs[id_ex_o.rs1];
        id_ex_o.rs2_val = (id_ex_o.rs2 == '0) ? '0 : regs[id_ex_o.rs2];
        if (wb_i.valid && wb_i.wb_en && wb_i.rd == id_ex_o.rs1) begin
            id_ex_o.rs1_val = wb_i.data;   // same-cycle write bypass
        end
        if (wb_i.valid && wb_i.wb_en && wb_i.rd == id_ex_o.rs2) begin
            id_ex_o.rs2_val = wb_i.data;
        end
    end

    assign load_use_o = valid_q && ex_i.valid && ex_i.is_load && ex_i.rd != '0 &&
                        (ex_i.rd == id_ex_o.rs1 || ex_i.rd == id_ex_o.rs2);

    // decode drops wb_en for rd 0, so nothing reaching writeback may target x0
    a_no_x0_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_i.valid && wb_i.wb_en |-> wb_i.rd != '0);

endmodule

// ==== hdl/ex_stage.sv ====
module ex_stage (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  logic              bubble_i,
    input  core_pkg::id_ex_t  id_ex_i,
    input  core_pkg::ex_ls_t  ls_i,
    input  core_pkg::wb_t     wb_i,
    output core_pkg::ex_ls_t  ex_ls_o,
    output logic              redirect_o,
    output core_pkg::word_t   target_o
);

    core_pkg::id_ex_t q;
    core_pkg::word_t  op_a;
    core_pkg::word_t  op_b;
    core_pkg::word_t  rhs;
    core_pkg::word_t  result;
    logic             taken;

    function automatic core_pkg::word_t forward(input core_pkg::reg_idx_t idx,
                                                input core_pkg::word_t    own,
                                                input core_pkg::ex_ls_t   ls,
                                                input core_pkg::wb_t      wb);
        core_pkg::fwd_sel_e sel;
        sel = core_pkg::FWD_NONE;
        if (wb.valid && wb.wb_en && wb.rd == idx) begin
            sel = core_pkg::FWD_WB;
        end
        if (ls.valid && ls.wb_en && !ls.is_load && ls.rd == idx) begin
            sel = core_pkg::FWD_LS;   // younger result wins
        end
        case (sel)
            core_pkg::FWD_LS: return ls.result;
            core_pkg::FWD_WB: return wb.data;
            default:          return own;
        endcase
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q <= '0;
        end else if (stall_i) begin
            q.rs1_val <= op_a;   // writeback may leave while frozen
            q.rs2_val <= op_b;
        end else if (flush_i || bubble_i) begin
            q.valid <= 1'b0;
        end else begin
            q <= id_ex_i;
        end
    end

    assign op_a = forward(q.rs1, q.rs1_val, ls_i, wb_i);
    assign op_b = forward(q.rs2, q.rs2_val, ls_i, wb_i);
    assign rhs  = q.use_imm ? q.imm : op_b;

    always_comb begin
        case (q.alu_op)
            core_pkg::ALU_SUB:    result = op_a - rhs;
            core_pkg::ALU_AND:    result = op_a & rhs;
            core_pkg::ALU_OR:     result = op_a | rhs;
            core_pkg::ALU_XOR:    result = op_a ^ rhs;
            core_pkg::ALU_PASS_B: result = rhs;
            default:              result = op_a + rhs;
        endcase
        if (q.is_jal) begin
            result = q.pc + 32'd4;   // link address
        end
    end

    assign taken = q.is_jal || (q.is_branch_eq && op_a == op_b) ||
                   (q.is_branch_ne && op_a != op_b);
    assign redirect_o = q.valid && taken;
    assign target_o   = q.pc + q.imm;

    always_comb begin
        ex_ls_o.valid      = q.valid;
        ex_ls_o.pc         = q.pc;
        ex_ls_o.result     = result;
        ex_ls_o.store_data = op_b;
        ex_ls_o.rd         = q.rd;
        ex_ls_o.is_load    = q.valid && q.is_load;
        ex_ls_o.is_store   = q.valid && q.is_store;
        ex_ls_o.wb_en      = q.valid && q.wb_en;
    end

endmodule

// ==== hdl/ls_stage.sv ====
module ls_stage (
    input  logic              clk,
    input  logic              arst_n_i,
    input  core_pkg::ex_ls_t  ex_ls_i,
    output bus_pkg::wb_req_t  dbus_req_o,
    input  bus_pkg::wb_rsp_t  dbus_rsp_i,
    output logic              mem_wait_o,
    output core_pkg::ex_ls_t  ls_o,
    output core_pkg::wb_t     wb_o
);

    core_pkg::ex_ls_t q;
    logic             mem_op;

    assign mem_op     = q.valid && (q.is_load || q.is_store);
    assign mem_wait_o = mem_op && !dbus_rsp_i.ack;
    assign ls_o       = q;

    always_comb begin
        dbus_req_o.cyc = mem_op;
        dbus_req_o.stb = mem_op;
        dbus_req_o.we  = q.is_store;
        dbus_req_o.adr = q.result;
        dbus_req_o.dat = q.store_data;
        dbus_req_o.sel = '1;   // word accesses only
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q    <= '0;
            wb_o <= '0;
        end else begin
            if (!mem_wait_o) begin
                q <= ex_ls_i;
            end
            wb_o.valid <= q.valid && !mem_wait_o;   // nothing retires during a wait
            wb_o.pc    <= q.pc;
            wb_o.rd    <= q.rd;
            wb_o.data  <= q.is_load ? dbus_rsp_i.dat : q.result;
            wb_o.wb_en <= q.wb_en;
        end
    end

    // execute only marks a store on a valid entry
    a_we_with_stb: assert property (@(posedge clk) disable iff (!arst_n_i)
        dbus_req_o.we |-> dbus_req_o.stb);

endmodule

// ==== hdl/pipeline_ctrl.sv ====
module pipeline_ctrl (
    input  logic load_use_i,
    input  logic redirect_i,
    input  logic fetch_wait_i,
    input  logic mem_wait_i,
    output logic stall_if_o,
    output logic stall_id_o,
    output logic stall_ex_o,
    output logic flush_id_o,
    output logic flush_ex_o,
    output logic bubble_ex_o
);

    // a data bus wait freezes every stage
    assign stall_ex_o = mem_wait_i;

    // load-use holds fetch and decode for one cycle
    assign stall_if_o = mem_wait_i || load_use_i;
    assign stall_id_o = mem_wait_i || load_use_i;

    assign flush_ex_o = !mem_wait_i && redirect_i;
    assign flush_id_o = !mem_wait_i && (redirect_i || (fetch_wait_i && !load_use_i));

    assign bubble_ex_o = !mem_wait_i && !redirect_i && load_use_i;   // never both in practice

endmodule

// ==== hdl/core_top.sv ====
module core_top #(
    parameter core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic             clk,
    input  logic             arst_n_i,
    output bus_pkg::wb_req_t ibus_req_o,
    input  bus_pkg::wb_rsp_t ibus_rsp_i,
    output bus_pkg::wb_req_t dbus_req_o,
    input  bus_pkg::wb_rsp_t dbus_rsp_i,
    output core_pkg::wb_t    retire_o
);

    logic             stall_if;
    logic             stall_id;
    logic             stall_ex;
    logic             flush_id;
    logic             flush_ex;
    logic             bubble_ex;
    logic             load_use;
    logic             redirect;
    logic             fetch_wait;
    logic             mem_wait;
    logic             if_valid;
    core_pkg::word_t  target;
    core_pkg::word_t  if_instr;
    core_pkg::word_t  if_pc;
    core_pkg::id_ex_t id_ex;
    core_pkg::id_ex_t ex_view;
    core_pkg::ex_ls_t ex_ls;
    core_pkg::ex_ls_t ls_fwd;
    core_pkg::wb_t    wb;

    // hazard check in decode only needs the load and its rd
    always_comb begin
        ex_view         = '0;
        ex_view.valid   = ex_ls.valid;
        ex_view.rd      = ex_ls.rd;
        ex_view.is_load = ex_ls.is_load;
    end

    assign retire_o = wb;

    if_stage #(
        .RESET_PC (RESET_PC)
    ) if_u (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .stall_i      (stall_if),
        .redirect_i   (redirect),
        .target_i     (target),
        .ibus_req_o   (ibus_req_o),
        .ibus_rsp_i   (ibus_rsp_i),
        .instr_o      (if_instr),
        .pc_o         (if_pc),
        .valid_o      (if_valid),
        .fetch_wait_o (fetch_wait)
    );

    id_stage id_u (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall_id),
        .flush_i    (flush_id),
        .instr_i    (if_instr),
        .pc_i       (if_pc),
        .valid_i    (if_valid),
        .wb_i       (wb),
        .ex_i       (ex_view),
        .id_ex_o    (id_ex),
        .load_use_o (load_use)
    );

    ex_stage ex_u (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall_ex),
        .flush_i    (flush_ex),
        .bubble_i   (bubble_ex),
        .id_ex_i    (id_ex),
        .ls_i       (ls_fwd),
        .wb_i       (wb),
        .ex_ls_o    (ex_ls),
        .redirect_o (redirect),
        .target_o   (target)
    );

    ls_stage ls_u (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .ex_ls_i    (ex_ls),
        .dbus_req_o (dbus_req_o),
        .dbus_rsp_i (dbus_rsp_i),
        .mem_wait_o (mem_wait),
        .ls_o       (ls_fwd),
        .wb_o       (wb)
    );

    pipeline_ctrl ctrl_u (
        .load_use_i   (load_use),
        .redirect_i   (redirect),
        .fetch_wait_i (fetch_wait),
        .mem_wait_i   (mem_wait),
        .stall_if_o   (stall_if),
        .stall_id_o   (stall_id),
        .stall_ex_o   (stall_ex),
        .flush_id_o   (flush_id),
        .flush_ex_o   (flush_ex),
        .bubble_ex_o  (bubble_ex)
    );

endmodule

// ==== verification/core_tb.sv ====
module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam core_pkg::word_t RESET_PC = 32'h0000_0100;
    localparam int CLK_PERIOD  = 10;
    localparam int RST_CYCLES  = 4;
    localparam int PROG_LEN    = 28;
    localparam int EXP_LEN     = 22;
    localparam int MEM_OPS     = 3;   // loads and stores in the program
    localparam int MAX_WAIT    = 3;
    localparam int PASS_CYCLES = (PROG_LEN + MEM_OPS) * (MAX_WAIT + 1) + 20;
    localparam int RUN_CYCLES  = 2 * (PASS_CYCLES + RST_CYCLES + 2);

    logic             clk;
    logic             arst_n;
    bus_pkg::wb_req_t ibus_req;
    bus_pkg::wb_rsp_t ibus_rsp;
    bus_pkg::wb_req_t dbus_req;
    bus_pkg::wb_rsp_t dbus_rsp;
    core_pkg::wb_t    retire;

    core_pkg::word_t  rom [64];
    core_pkg::word_t  dram [64];
    core_pkg::word_t  prog [PROG_LEN];
    core_pkg::wb_t    exp_tab [EXP_LEN];

    int               checks;
    int               errors;
    int               ret_idx;
    logic             checking;
    logic             fast_ack;
    logic             i_busy;
    logic             d_busy;
    int               i_left;
    int               d_left;

    core_top #(
        .RESET_PC (RESET_PC)
    ) dut0 (
        .clk        (clk),
        .arst_n_i   (arst_n),
        .ibus_req_o (ibus_req),
        .ibus_rsp_i (ibus_rsp),
        .dbus_req_o (dbus_req),
        .dbus_rsp_i (dbus_rsp),
        .retire_o   (retire)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // rv32i instruction formats
    function automatic core_pkg::word_t i_type(int imm, int rs1, int f3, int rd, int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic core_pkg::word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic core_pkg::word_t s_type(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic core_pkg::word_t b_type(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic core_pkg::word_t u_type(int imm20, int rd);
        return {imm20[19:0], rd[4:0], 7'h37};
    endfunction

    function automatic core_pkg::word_t j_type(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic core_pkg::wb_t retire_entry(int off, int rd, core_pkg::word_t data,
                                                   int wb_en);
        core_pkg::wb_t r;
        r       = '0;
        r.valid = 1'b1;
        r.pc    = RESET_PC + off;
        r.rd    = rd[4:0];
        r.data  = data;
        r.wb_en = (wb_en != 0);
        return r;
    endfunction

    // word at byte address idx*4
    function automatic core_pkg::word_t fill_word(int idx);
        return 32'hC0DE_0000 | (idx * 4);
    endfunction

    function automatic int ack_delay();
        if (fast_ack) begin
            return 0;
        end
        return $urandom % (MAX_WAIT + 1);
    endfunction

    task automatic expect_eq(input string name, input core_pkg::word_t got,
                             input core_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic load_tables();
        prog[0]  = i_type(5, 0, 0, 1, 'h13);        // addi x1, x0, 5
        prog[1]  = i_type(7, 1, 0, 2, 'h13);        // addi x2, x1, 7
        prog[2]  = r_type('h00, 2, 1, 0, 3);        // add x3, x1, x2
        prog[3]  = r_type('h20, 1, 3, 0, 4);        // sub x4, x3, x1
        prog[4]  = r_type('h00, 3, 4, 6, 5);        // or x5, x4, x3
        prog[5]  = r_type('h00, 2, 5, 4, 6);        // xor x6, x5, x2
        prog[6]  = r_type('h00, 5, 6, 7, 7);        // and x7, x6, x5
        prog[7]  = u_type('h12345, 8);              // lui x8
        prog[8]  = r_type('h00, 7, 8, 0, 8);        // add x8, x8, x7
        prog[9]  = i_type('h40, 0, 0, 9, 'h13);     // addi x9, x0, 0x40
        prog[10] = i_type(0, 9, 2, 10, 'h03);       // lw x10, 0(x9)
        prog[11] = r_type('h00, 1, 10, 0, 11);      // add x11, x10, x1 (load-use)
        prog[12] = s_type(8, 8, 9);                 // sw x8, 8(x9)
        prog[13] = i_type(8, 9, 2, 12, 'h03);       // lw x12, 8(x9)
        prog[14] = i_type(99, 1, 0, 0, 'h13);       // addi x0, x1, 99
        prog[15] = r_type('h00, 1, 0, 0, 13);       // add x13, x0, x1
        prog[16] = b_type(12, 13, 1, 0);            // beq x1, x13, taken
        prog[17] = i_type(1, 0, 0, 14, 'h13);       // shadow
        prog[18] = i_type(2, 0, 0, 14, 'h13);       // shadow
        prog[19] = b_type(12, 2, 1, 1);             // bne x1, x2, taken
        prog[20] = i_type(3, 0, 0, 15, 'h13);
        prog[21] = i_type(4, 0, 0, 15, 'h13);
        prog[22] = b_type(8, 2, 1, 0);              // beq not taken
        prog[23] = j_type(12, 16);                  // jal x16, +12
        prog[24] = i_type(5, 0, 0, 17, 'h13);
        prog[25] = i_type(6, 0, 0, 17, 'h13);
        prog[26] = r_type('h00, 11, 16, 0, 18);     // add x18, x16, x11
        prog[27] = j_type(0, 0);                    // park here

        exp_tab[0]  = retire_entry('h00, 1, 32'h0000_0005, 1);
        exp_tab[1]  = retire_entry('h04, 2, 32'h0000_000C, 1);
        exp_tab[2]  = retire_entry('h08, 3, 32'h0000_0011, 1);
        exp_tab[3]  = retire_entry('h0C, 4, 32'h0000_000C, 1);
        exp_tab[4]  = retire_entry('h10, 5, 32'h0000_001D, 1);
        exp_tab[5]  = retire_entry('h14, 6, 32'h0000_0011, 1);
        exp_tab[6]  = retire_entry('h18, 7, 32'h0000_0011, 1);
        exp_tab[7]  = retire_entry('h1C, 8, 32'h1234_5000, 1);
        exp_tab[8]  = retire_entry('h20, 8, 32'h1234_5011, 1);
        exp_tab[9]  = retire_entry('h24, 9, 32'h0000_0040, 1);
        exp_tab[10] = retire_entry('h28, 10, 32'hC0DE_0040, 1);
        exp_tab[11] = retire_entry('h2C, 11, 32'hC0DE_0045, 1);
        exp_tab[12] = retire_entry('h30, 0, 32'h0, 0);      // store
        exp_tab[13] = retire_entry('h34, 12, 32'h1234_5011, 1);
        exp_tab[14] = retire_entry('h38, 0, 32'h0, 0);      // x0 target
        exp_tab[15] = retire_entry('h3C, 13, 32'h0000_0005, 1);
        exp_tab[16] = retire_entry('h40, 0, 32'h0, 0);
        exp_tab[17] = retire_entry('h4C, 0, 32'h0, 0);
        exp_tab[18] = retire_entry('h58, 0, 32'h0, 0);
        exp_tab[19] = retire_entry('h5C, 16, 32'h0000_0160, 1);   // link = pc+4
        exp_tab[20] = retire_entry('h68, 18, 32'hC0DE_01A5, 1);
        exp_tab[21] = retire_entry('h6C, 0, 32'h0, 0);
    endtask

    // both wishbone slaves, ack after 0..MAX_WAIT idle cycles
    always @(posedge clk) begin
        #1;
        ibus_rsp = '0;
        dbus_rsp = '0;
        if (!arst_n) begin
            i_busy = 1'b0;
            d_busy = 1'b0;
        end else begin
            if (ibus_req.cyc && ibus_req.stb) begin
                if (!i_busy) begin
                    i_busy = 1'b1;
                    i_left = ack_delay();
                end
                if (i_left == 0) begin
                    ibus_rsp.ack = 1'b1;
                    ibus_rsp.dat = rom[ibus_req.adr[7:2]];
                    i_busy       = 1'b0;
                end else begin
                    i_left--;
                end
            end
            if (dbus_req.cyc && dbus_req.stb) begin
                if (!d_busy) begin
                    d_busy = 1'b1;
                    d_left = ack_delay();
                end
                if (d_left == 0) begin
                    dbus_rsp.ack = 1'b1;
                    if (dbus_req.we) begin
                        dram[dbus_req.adr[7:2]] = dbus_req.dat;
                    end else begin
                        dbus_rsp.dat = dram[dbus_req.adr[7:2]];
                    end
                    d_busy = 1'b0;
                end else begin
                    d_left--;
                end
            end
        end
    end

    // retire trace against the table, in order
    always @(negedge clk) begin
        if (checking && retire.valid && ret_idx < EXP_LEN) begin
            expect_eq($sformatf("retire[%0d].pc", ret_idx), retire.pc, exp_tab[ret_idx].pc);
            expect_eq($sformatf("retire[%0d].wb_en", ret_idx), {31'd0, retire.wb_en},
                      {31'd0, exp_tab[ret_idx].wb_en});
            if (exp_tab[ret_idx].wb_en) begin
                expect_eq($sformatf("retire[%0d].rd", ret_idx), {27'd0, retire.rd},
                          {27'd0, exp_tab[ret_idx].rd});
                expect_eq($sformatf("retire[%0d].data", ret_idx), retire.data,
                          exp_tab[ret_idx].data);
            end
            ret_idx++;
        end
    end

    task automatic run_pass(input logic fast);
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        @(negedge clk);
        checking = 1'b0;
        ret_idx  = 0;
        fast_ack = fast;
        for (int i = 0; i < 64; i++) begin
            rom[i]  = (i < PROG_LEN) ? prog[i] : i_type(0, 0, 0, 0, 'h13);
            dram[i] = fill_word(i);
        end
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        arst_n   = 1'b1;
        checking = 1'b1;
        wait (ret_idx >= EXP_LEN);
        checking = 1'b0;
        expect_eq("dram[0x48]", dram[18], 32'h1234_5011);   // stored word stays
        expect_eq("dram[0x40]", dram[16], fill_word(16));
    endtask

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("timeout: retire trace not complete after %0d cycles", RUN_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(67005));
        clk      = 1'b0;
        arst_n   = 1'b0;
        ibus_rsp = '0;
        dbus_rsp = '0;
        checks   = 0;
        errors   = 0;
        ret_idx  = 0;
        checking = 1'b0;
        fast_ack = 1'b0;
        i_busy   = 1'b0;
        d_busy   = 1'b0;
        i_left   = 0;
        d_left   = 0;
        load_tables();
        run_pass(1'b0);   // random ack delays
        run_pass(1'b1);   // every ack immediate
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hdl/core_pkg.sv
hdl/bus_pkg.sv
hdl/if_stage.sv
hdl/id_stage.sv
hdl/ex_stage.sv
hdl/ls_stage.sv
hdl/pipeline_ctrl.sv
hdl/core_top.sv
verification/core_tb.sv

// ==== Makefile ====
SRCS := $(shell cat filelist.f)

.PHONY: all run clean

all: run

obj_dir/Vcore_tb: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module core_tb -f filelist.f -o Vcore_tb

run: obj_dir/Vcore_tb
	@out="$$(./obj_dir/Vcore_tb)"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
